// ==== hdl/fb_settings.svh ====
// Framebuffer clear settings
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// Screen coordinate and resolution width
`define FB_SCREEN_POS_WIDTH 11

// Byte address width of the framebuffer memory
`define FB_ADDR_WIDTH 32

// One RGB565 pixel per memory word
`define FB_MEM_DATA_WIDTH 16
`define FB_MEM_STRB_WIDTH 2

// Auxiliary buffer widths
`define FB_STENCIL_WIDTH 4
`define FB_DEPTH_WIDTH 16

`endif

// ==== hdl/raster_pkg.sv ====
// Framebuffer clear types
`include "fb_settings.svh"

package raster_pkg;

    // Screen space
    typedef logic [`FB_SCREEN_POS_WIDTH - 1 : 0] screen_pos_t;

    // Memory side
    typedef logic [`FB_ADDR_WIDTH - 1 : 0]     fb_addr_t;
    typedef logic [`FB_MEM_DATA_WIDTH - 1 : 0] mem_word_t;
    typedef logic [`FB_MEM_STRB_WIDTH - 1 : 0] mem_strb_t;

    // Pixel payloads of the three buffers
    typedef logic [15 : 0]                     rgb565_t;
    typedef logic [`FB_DEPTH_WIDTH - 1 : 0]    depth_t;
    typedef logic [`FB_STENCIL_WIDTH - 1 : 0]  stencil_t;

    // Area to clear, end coordinates are exclusive
    // line_stride is the x resolution in pixels
    typedef struct packed {
        screen_pos_t x_start;
        screen_pos_t x_end;
        screen_pos_t y_start;
        screen_pos_t y_end;
        screen_pos_t line_stride;
    } clear_rect_t;

endpackage

// ==== hdl/fb_mem_if.sv ====
// Framebuffer memory write port
`timescale 1ns/1ps

interface fb_mem_if;
    import raster_pkg::*;

    // Request held stable until wready is seen on a rising edge
    logic      wvalid;
    logic      wready;
    fb_addr_t  waddr;
    mem_word_t wdata;
    mem_strb_t wstrb;

    modport requester
    (
        output wvalid,
        output waddr,
        output wdata,
        output wstrb,
        input  wready
    );

    modport arbiter
    (
        input  wvalid,
        input  waddr,
        input  wdata,
        input  wstrb,
        output wready
    );

endinterface

// ==== hdl/fb_cmd_sequencer.sv ====
// Framebuffer command sequencer
`timescale 1ns/1ps

module fb_cmd_sequencer
(
    input  logic                    aclk,
    input  logic                    arst_n,

    input  logic                    apply,
    input  logic                    cmd_memset_color,
    input  logic                    cmd_memset_depth,
    input  logic                    cmd_memset_stencil,
    input  logic                    cmd_swap,

    input  logic                    enable_scissor,
    input  raster_pkg::screen_pos_t scissor_start_x,
    input  raster_pkg::screen_pos_t scissor_start_y,
    input  raster_pkg::screen_pos_t scissor_end_x,
    input  raster_pkg::screen_pos_t scissor_end_y,
    input  raster_pkg::screen_pos_t x_resolution,
    input  raster_pkg::screen_pos_t y_resolution,

    input  logic                    color_mask,
    input  logic                    depth_mask,
    input  logic                    stencil_mask,
    input  raster_pkg::fb_addr_t    color_addr,

    input  logic                    color_done,
    input  logic                    depth_done,
    input  logic                    stencil_done,
    input  logic                    fb_swapped,

    output logic                    color_start,
    output logic                    depth_start,
    output logic                    stencil_start,
    output logic                    busy,
    output logic                    applied,
    output logic                    swap_fb,
    output raster_pkg::clear_rect_t clear_rect,
    output raster_pkg::fb_addr_t    fb_addr
);
    import raster_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_WAIT_SWAP
    } state_t;

    state_t      state;
    logic [2:0]  start_q;
    logic [2:0]  pending;
    logic [2:0]  pending_left;
    logic [2:0]  launch;
    logic        swap_q;
    clear_rect_t rect_next;

    // Lower of a coordinate and the screen limit
    function automatic screen_pos_t clip(input screen_pos_t pos, input screen_pos_t limit);
        return (pos < limit) ? pos : limit;
    endfunction

    // Bit 0 colour, bit 1 depth, bit 2 stencil
    assign launch = {cmd_memset_stencil & stencil_mask,
                     cmd_memset_depth & depth_mask,
                     cmd_memset_color & color_mask};

    assign pending_left = pending & ~{stencil_done, depth_done, color_done};

    assign color_start   = start_q[0];
    assign depth_start   = start_q[1];
    assign stencil_start = start_q[2];

    always_comb
    begin
        rect_next.line_stride = x_resolution;
        if (enable_scissor)
        begin
            rect_next.x_start = clip(scissor_start_x, x_resolution);
            rect_next.x_end   = clip(scissor_end_x, x_resolution);
            rect_next.y_start = clip(scissor_start_y, y_resolution);
            rect_next.y_end   = clip(scissor_end_y, y_resolution);
        end
        else
        begin
            rect_next.x_start = '0;
            rect_next.x_end   = x_resolution;
            rect_next.y_start = '0;
            rect_next.y_end   = y_resolution;
        end
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= ST_IDLE;
            start_q <= '0;
            pending <= '0;
            swap_q  <= 1'b0;
            busy    <= 1'b0;
            applied <= 1'b0;
            swap_fb <= 1'b0;
            fb_addr <= '0;
        end
        else
        begin
            start_q <= '0;
            applied <= 1'b0;
            swap_fb <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (apply)
                    begin
                        start_q <= launch;
                        pending <= launch;
                        swap_q  <= cmd_swap;
                        fb_addr <= color_addr;
                        busy    <= 1'b1;
                        state   <= ST_CLEAR;
                    end
                end
                ST_CLEAR:
                begin
                    pending <= pending_left;
                    if (pending_left == 3'b000)
                    begin
                        if (swap_q)
                        begin
                            swap_fb <= 1'b1;
                            state   <= ST_WAIT_SWAP;
                        end
                        else
                        begin
                            applied <= 1'b1;
                            busy    <= 1'b0;
                            state   <= ST_IDLE;
                        end
                    end
                end
                ST_WAIT_SWAP:
                begin
                    // Display confirms the swap with a level
                    if (fb_swapped)
                    begin
                        applied <= 1'b1;
                        busy    <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Rectangle stays stable while the units walk it
    always_ff @(posedge aclk)
    begin
        if ((state == ST_IDLE) && apply)
        begin
            clear_rect <= rect_next;
        end
    end

endmodule

// ==== hdl/fb_clear_unit.sv ====
// Buffer clear unit
`timescale 1ns/1ps

module fb_clear_unit #(
    parameter type pixel_t = raster_pkg::rgb565_t
)
(
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    start,
    input  raster_pkg::clear_rect_t clear_rect,
    input  raster_pkg::fb_addr_t    base_addr,
    input  pixel_t                  clear_value,
    fb_mem_if.requester             mem,
    output logic                    done
);
    import raster_pkg::*;

    // Pixel index y * stride + x needs two coordinate widths
    localparam int IDX_WIDTH = 2 * $bits(screen_pos_t);
    localparam int PIXEL_BYTES = ($bits(pixel_t) + 7) / 8;
    localparam mem_strb_t PIXEL_STRB = mem_strb_t'((1 << PIXEL_BYTES) - 1);

    logic                     wvalid_q;
    fb_addr_t                 base_q;
    pixel_t                   value_q;
    screen_pos_t              x_q;
    screen_pos_t              y_q;
    screen_pos_t              x_next;
    screen_pos_t              y_next;
    logic [IDX_WIDTH - 1 : 0] row_idx_q;
    logic [IDX_WIDTH - 1 : 0] pixel_idx;
    logic                     rect_empty;
    logic                     accept;
    logic                     last_x;
    logic                     last_pixel;

    assign rect_empty = (clear_rect.x_start >= clear_rect.x_end)
                     || (clear_rect.y_start >= clear_rect.y_end);
    assign accept     = wvalid_q && mem.wready;
    assign x_next     = x_q + 1'b1;
    assign y_next     = y_q + 1'b1;
    assign last_x     = (x_next == clear_rect.x_end);
    assign last_pixel = last_x && (y_next == clear_rect.y_end);
    assign pixel_idx  = row_idx_q + IDX_WIDTH'(x_q);

    // Byte address of a 16 bit word
    assign mem.wvalid = wvalid_q;
    assign mem.waddr  = base_q + fb_addr_t'({pixel_idx, 1'b0});
    assign mem.wdata  = mem_word_t'(value_q);
    assign mem.wstrb  = PIXEL_STRB;

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wvalid_q <= 1'b0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                // Nothing to write, finish right away
                wvalid_q <= !rect_empty;
                done     <= rect_empty;
            end
            else if (accept && last_pixel)
            begin
                wvalid_q <= 1'b0;
                done     <= 1'b1;
            end
        end
    end

    // Walk x first, then y
    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            base_q    <= base_addr;
            value_q   <= clear_value;
            x_q       <= clear_rect.x_start;
            y_q       <= clear_rect.y_start;
            row_idx_q <= IDX_WIDTH'(clear_rect.y_start) * IDX_WIDTH'(clear_rect.line_stride);
        end
        else if (accept)
        begin
            if (last_x)
            begin
                x_q       <= clear_rect.x_start;
                y_q       <= y_next;
                row_idx_q <= row_idx_q + IDX_WIDTH'(clear_rect.line_stride);
            end
            else
            begin
                x_q <= x_next;
            end
        end
    end

endmodule

// ==== hdl/fb_write_arbiter.sv ====
// Round-robin memory write arbiter
`timescale 1ns/1ps

module fb_write_arbiter
(
    input  logic                  aclk,
    input  logic                  arst_n,
    fb_mem_if.arbiter             color_port,
    fb_mem_if.arbiter             depth_port,
    fb_mem_if.arbiter             stencil_port,
    output logic                  mem_wvalid,
    output raster_pkg::fb_addr_t  mem_waddr,
    output raster_pkg::mem_word_t mem_wdata,
    output raster_pkg::mem_strb_t mem_wstrb,
    input  logic                  mem_wready
);
    import raster_pkg::*;

    logic [2:0] req;
    logic [1:0] rr_ptr;
    logic [1:0] cand1;
    logic [1:0] cand2;
    logic [1:0] grant;
    logic [1:0] grant_q;
    logic       lock_q;
    fb_addr_t   addr_arr [3];
    mem_word_t  data_arr [3];
    mem_strb_t  strb_arr [3];

    // Index 0 colour, 1 depth, 2 stencil
    assign req = {stencil_port.wvalid, depth_port.wvalid, color_port.wvalid};

    assign addr_arr[0] = color_port.waddr;
    assign addr_arr[1] = depth_port.waddr;
    assign addr_arr[2] = stencil_port.waddr;
    assign data_arr[0] = color_port.wdata;
    assign data_arr[1] = depth_port.wdata;
    assign data_arr[2] = stencil_port.wdata;
    assign strb_arr[0] = color_port.wstrb;
    assign strb_arr[1] = depth_port.wstrb;
    assign strb_arr[2] = stencil_port.wstrb;

    // Search order starting at the pointer
    assign cand1 = (rr_ptr == 2'd2) ? 2'd0 : rr_ptr + 2'd1;
    assign cand2 = (rr_ptr == 2'd0) ? 2'd2 : rr_ptr - 2'd1;

    always_comb
    begin
        if (lock_q)
            grant = grant_q;
        else if (req[rr_ptr])
            grant = rr_ptr;
        else if (req[cand1])
            grant = cand1;
        else
            grant = cand2;
    end

    assign mem_wvalid = req[grant];
    assign mem_waddr  = addr_arr[grant];
    assign mem_wdata  = data_arr[grant];
    assign mem_wstrb  = strb_arr[grant];

    assign color_port.wready   = mem_wready && (grant == 2'd0);
    assign depth_port.wready   = mem_wready && (grant == 2'd1);
    assign stencil_port.wready = mem_wready && (grant == 2'd2);

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rr_ptr  <= 2'd0;
            grant_q <= 2'd0;
            lock_q  <= 1'b0;
        end
        else
        begin
            // Stalled transfer keeps its grant
            lock_q  <= mem_wvalid && !mem_wready;
            grant_q <= grant;
            if (mem_wvalid && mem_wready)
            begin
                rr_ptr <= (grant == 2'd2) ? 2'd0 : grant + 2'd1;
            end
        end
    end

endmodule

// ==== hdl/fb_memset_top.sv ====
// Framebuffer memset top level
`timescale 1ns/1ps

module fb_memset_top
(
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    apply,
    input  logic                    cmd_memset_color,
    input  logic                    cmd_memset_depth,
    input  logic                    cmd_memset_stencil,
    input  logic                    cmd_swap,
    input  logic                    enable_scissor,
    input  raster_pkg::screen_pos_t scissor_start_x,
    input  raster_pkg::screen_pos_t scissor_start_y,
    input  raster_pkg::screen_pos_t scissor_end_x,
    input  raster_pkg::screen_pos_t scissor_end_y,
    input  raster_pkg::screen_pos_t x_resolution,
    input  raster_pkg::screen_pos_t y_resolution,
    input  raster_pkg::fb_addr_t    color_addr,
    input  raster_pkg::fb_addr_t    depth_addr,
    input  raster_pkg::fb_addr_t    stencil_addr,
    input  raster_pkg::rgb565_t     clear_color,
    input  raster_pkg::depth_t      clear_depth,
    input  raster_pkg::stencil_t    clear_stencil,
    input  logic                    color_mask,
    input  logic                    depth_mask,
    input  logic                    stencil_mask,
    input  logic                    fb_swapped,
    input  logic                    mem_wready,
    output logic                    busy,
    output logic                    applied,
    output logic                    swap_fb,
    output raster_pkg::fb_addr_t    fb_addr,
    output logic                    mem_wvalid,
    output raster_pkg::fb_addr_t    mem_waddr,
    output raster_pkg::mem_word_t   mem_wdata,
    output raster_pkg::mem_strb_t   mem_wstrb
);
    import raster_pkg::*;

    clear_rect_t clear_rect;
    logic        color_start;
    logic        depth_start;
    logic        stencil_start;
    logic        color_done;
    logic        depth_done;
    logic        stencil_done;

    fb_mem_if color_mem ();
    fb_mem_if depth_mem ();
    fb_mem_if stencil_mem ();

    fb_cmd_sequencer sequencer (
        .aclk               (aclk),
        .arst_n             (arst_n),
        .apply              (apply),
        .cmd_memset_color   (cmd_memset_color),
        .cmd_memset_depth   (cmd_memset_depth),
        .cmd_memset_stencil (cmd_memset_stencil),
        .cmd_swap           (cmd_swap),
        .enable_scissor     (enable_scissor),
        .scissor_start_x    (scissor_start_x),
        .scissor_start_y    (scissor_start_y),
        .scissor_end_x      (scissor_end_x),
        .scissor_end_y      (scissor_end_y),
        .x_resolution       (x_resolution),
        .y_resolution       (y_resolution),
        .color_mask         (color_mask),
        .depth_mask         (depth_mask),
        .stencil_mask       (stencil_mask),
        .color_addr         (color_addr),
        .color_done         (color_done),
        .depth_done         (depth_done),
        .stencil_done       (stencil_done),
        .fb_swapped         (fb_swapped),
        .color_start        (color_start),
        .depth_start        (depth_start),
        .stencil_start      (stencil_start),
        .busy               (busy),
        .applied            (applied),
        .swap_fb            (swap_fb),
        .clear_rect         (clear_rect),
        .fb_addr            (fb_addr)
    );

    // Colour base comes from the latched display address
    fb_clear_unit #(.pixel_t(rgb565_t)) color_clear (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .start       (color_start),
        .clear_rect  (clear_rect),
        .base_addr   (fb_addr),
        .clear_value (clear_color),
        .mem         (color_mem.requester),
        .done        (color_done)
    );

    fb_clear_unit #(.pixel_t(depth_t)) depth_clear (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .start       (depth_start),
        .clear_rect  (clear_rect),
        .base_addr   (depth_addr),
        .clear_value (clear_depth),
        .mem         (depth_mem.requester),
        .done        (depth_done)
    );

    fb_clear_unit #(.pixel_t(stencil_t)) stencil_clear (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .start       (stencil_start),
        .clear_rect  (clear_rect),
        .base_addr   (stencil_addr),
        .clear_value (clear_stencil),
        .mem         (stencil_mem.requester),
        .done        (stencil_done)
    );

    fb_write_arbiter arbiter (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .color_port   (color_mem.arbiter),
        .depth_port   (depth_mem.arbiter),
        .stencil_port (stencil_mem.arbiter),
        .mem_wvalid   (mem_wvalid),
        .mem_waddr    (mem_waddr),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_wready   (mem_wready)
    );

endmodule

// ==== verif/fb_memset_tb.sv ====
// Framebuffer memset testbench
`timescale 1ns/1ps

module fb_memset_tb;
    import raster_pkg::*;

    localparam int NUM_ROWS = 6;

    // Command bits and masks: bit 0 colour, bit 1 depth, bit 2 stencil
    typedef struct {
        logic [2:0]  memset;
        logic [2:0]  mask;
        logic        swap;
        logic        scissor;
        logic        reapply;
        int          sx;
        int          sy;
        int          ex;
        int          ey;
        int          xres;
        int          yres;
        logic [31:0] caddr;
        logic [31:0] daddr;
        logic [31:0] saddr;
        logic [15:0] ccolor;
        logic [15:0] cdepth;
        logic [3:0]  cstencil;
    } row_t;

    logic        aclk;
    logic        arst_n;
    logic        apply;
    logic        cmd_memset_color;
    logic        cmd_memset_depth;
    logic        cmd_memset_stencil;
    logic        cmd_swap;
    logic        enable_scissor;
    screen_pos_t scissor_start_x;
    screen_pos_t scissor_start_y;
    screen_pos_t scissor_end_x;
    screen_pos_t scissor_end_y;
    screen_pos_t x_resolution;
    screen_pos_t y_resolution;
    fb_addr_t    color_addr;
    fb_addr_t    depth_addr;
    fb_addr_t    stencil_addr;
    rgb565_t     clear_color;
    depth_t      clear_depth;
    stencil_t    clear_stencil;
    logic        color_mask;
    logic        depth_mask;
    logic        stencil_mask;
    logic        fb_swapped = 1'b0;
    logic        mem_wready = 1'b0;
    logic        busy;
    logic        applied;
    logic        swap_fb;
    fb_addr_t    fb_addr;
    logic        mem_wvalid;
    fb_addr_t    mem_waddr;
    mem_word_t   mem_wdata;
    mem_strb_t   mem_wstrb;

    row_t        rows [NUM_ROWS];

    // Memory model and expected image, keyed by byte address
    logic [15:0] mem_data [bit [31:0]];
    logic [1:0]  mem_strb [bit [31:0]];
    int          mem_count [bit [31:0]];
    logic [15:0] exp_data [bit [31:0]];
    logic [1:0]  exp_strb [bit [31:0]];

    logic [31:0] lcg_state = 32'h44e6;
    int          cycles = 0;
    int          cycle_limit = 200;
    int          write_total;
    int          writes_at_swap;
    int          applied_count;
    int          swap_count;
    int          swap_wait = 0;
    logic        drop_swapped = 1'b0;
    int          swapped_samples;
    int          swapped_at_applied;

    fb_memset_top DUT (.*);

    initial
    begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("** Error at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic clear_model();
        mem_data.delete();
        mem_strb.delete();
        mem_count.delete();
        exp_data.delete();
        exp_strb.delete();
        write_total        = 0;
        writes_at_swap     = 0;
        applied_count      = 0;
        swap_count         = 0;
        swapped_samples    = 0;
        swapped_at_applied = 0;
    endtask

    task automatic add_expected(input logic [31:0] addr, input logic [15:0] data,
                                input logic [1:0] strb);
        exp_data[addr] = data;
        exp_strb[addr] = strb;
    endtask

    // Expected image from the clear rules of each enabled buffer
    task automatic build_expected(input row_t rw);
        int          xs;
        int          xe;
        int          ys;
        int          ye;
        int          x;
        int          y;
        logic [31:0] offset;
        if (rw.scissor)
        begin
            xs = (rw.sx < rw.xres) ? rw.sx : rw.xres;
            xe = (rw.ex < rw.xres) ? rw.ex : rw.xres;
            ys = (rw.sy < rw.yres) ? rw.sy : rw.yres;
            ye = (rw.ey < rw.yres) ? rw.ey : rw.yres;
        end
        else
        begin
            xs = 0;
            xe = rw.xres;
            ys = 0;
            ye = rw.yres;
        end
        for (y = ys; y < ye; y++)
        begin
            for (x = xs; x < xe; x++)
            begin
                // Two bytes per pixel
                offset = 32'(2 * (y * rw.xres + x));
                if (rw.memset[0] && rw.mask[0])
                    add_expected(rw.caddr + offset, rw.ccolor, 2'b11);
                if (rw.memset[1] && rw.mask[1])
                    add_expected(rw.daddr + offset, rw.cdepth, 2'b11);
                if (rw.memset[2] && rw.mask[2])
                    add_expected(rw.saddr + offset, {12'h000, rw.cstencil}, 2'b01);
            end
        end
    endtask

    task automatic record_write();
        bit [31:0] a;
        a = mem_waddr;
        assert (exp_data.exists(a))
        else stop_on_error($sformatf("Write to unexpected address %h at %0t", a, $time));
        write_total++;
        if (mem_count.exists(a))
            mem_count[a]++;
        else
            mem_count[a] = 1;
        mem_data[a] = mem_wdata;
        mem_strb[a] = mem_wstrb;
    endtask

    task automatic compare_memory();
        check_value("write total", 32'(write_total), 32'(exp_data.num()));
        foreach (exp_data[a])
        begin
            assert (mem_count.exists(a))
            else stop_on_error($sformatf("No write reached address %h", a));
            check_value($sformatf("write count at %h", a), 32'(mem_count[a]), 32'd1);
            check_value($sformatf("mem_wdata at %h", a), 32'(mem_data[a]), 32'(exp_data[a]));
            check_value($sformatf("mem_wstrb at %h", a), 32'(mem_strb[a]), 32'(exp_strb[a]));
        end
    endtask

    task automatic drive_row(input row_t rw);
        cmd_memset_color   = rw.memset[0];
        cmd_memset_depth   = rw.memset[1];
        cmd_memset_stencil = rw.memset[2];
        color_mask         = rw.mask[0];
        depth_mask         = rw.mask[1];
        stencil_mask       = rw.mask[2];
        cmd_swap           = rw.swap;
        enable_scissor     = rw.scissor;
        scissor_start_x    = screen_pos_t'(rw.sx);
        scissor_start_y    = screen_pos_t'(rw.sy);
        scissor_end_x      = screen_pos_t'(rw.ex);
        scissor_end_y      = screen_pos_t'(rw.ey);
        x_resolution       = screen_pos_t'(rw.xres);
        y_resolution       = screen_pos_t'(rw.yres);
        color_addr         = rw.caddr;
        depth_addr         = rw.daddr;
        stencil_addr       = rw.saddr;
        clear_color        = rw.ccolor;
        clear_depth        = rw.cdepth;
        clear_stencil      = rw.cstencil;
    endtask

    task automatic run_row(input int r);
        row_t rw;
        rw = rows[r];
        clear_model();
        build_expected(rw);
        @(negedge aclk);
        check_value("busy", 32'(busy), 32'd0);
        drive_row(rw);
        apply = 1'b1;
        @(negedge aclk);
        apply = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        // Second apply lands while busy
        if (rw.reapply)
        begin
            @(negedge aclk);
            check_value("busy", 32'(busy), 32'd1);
            apply = 1'b1;
            @(negedge aclk);
            apply = 1'b0;
        end
        while (applied_count == 0)
            @(negedge aclk);
        check_value("busy", 32'(busy), 32'd0);
        // Window for stray writes and pulses
        repeat (6) @(negedge aclk);
        check_value("applied pulses", 32'(applied_count), 32'd1);
        check_value("swap_fb pulses", 32'(swap_count), 32'(rw.swap));
        check_value("fb_addr", fb_addr, rw.caddr);
        if (rw.swap)
        begin
            check_value("writes before swap_fb", 32'(writes_at_swap), 32'(exp_data.num()));
            check_value("fb_swapped samples before applied", 32'(swapped_at_applied), 32'd1);
        end
        compare_memory();
    endtask

    task automatic fill_table();
        // Full screen, all buffers
        rows[0] = '{3'b111, 3'b111, 1'b0, 1'b0, 1'b0, 0, 0, 0, 0, 8, 4,
                    32'h0001_0000, 32'h0002_0000, 32'h0003_0000, 16'hf81f, 16'habcd, 4'h5};
        rows[1] = '{3'b111, 3'b111, 1'b1, 1'b0, 1'b1, 0, 0, 0, 0, 16, 8,
                    32'h0001_1000, 32'h0002_1000, 32'h0003_1000, 16'h07e0, 16'h1234, 4'ha};
        // Scissor inside the screen
        rows[2] = '{3'b111, 3'b111, 1'b1, 1'b1, 1'b0, 3, 1, 9, 5, 12, 6,
                    32'h0001_2000, 32'h0002_2000, 32'h0003_2000, 16'h001f, 16'hffff, 4'hf};
        // Scissor clipped, depth memset off
        rows[3] = '{3'b101, 3'b111, 1'b0, 1'b1, 1'b1, 6, 2, 20, 9, 10, 5,
                    32'h0001_3000, 32'h0002_3000, 32'h0003_3000, 16'h5aa5, 16'h0f0f, 4'h3};
        // Empty after clipping
        rows[4] = '{3'b111, 3'b111, 1'b1, 1'b1, 1'b0, 9, 0, 12, 4, 8, 4,
                    32'h0001_4000, 32'h0002_4000, 32'h0003_4000, 16'h8001, 16'h7777, 4'h9};
        // Colour mask off, stencil memset off
        rows[5] = '{3'b011, 3'b010, 1'b1, 1'b0, 1'b0, 0, 0, 0, 0, 16, 8,
                    32'h0001_5000, 32'h0002_5000, 32'h0003_5000, 16'hc3c3, 16'h2468, 4'h6};
    endtask

    // Random back-pressure and the display side of the swap
    always @(negedge aclk)
    begin
        lcg_state  = next_random(lcg_state);
        mem_wready = (lcg_state[31:30] != 2'b00);
        if (drop_swapped)
        begin
            fb_swapped   = 1'b0;
            drop_swapped = 1'b0;
        end
        else if (swap_wait > 0)
        begin
            swap_wait--;
            if (swap_wait == 0)
                fb_swapped = 1'b1;
        end
    end

    // Outputs are sampled midway through the low phase
    always @(negedge aclk)
    begin
        #1;
        if (arst_n)
        begin
            if (mem_wvalid && mem_wready)
                record_write();
            if (swap_fb)
            begin
                swap_count++;
                writes_at_swap = write_total;
                lcg_state      = next_random(lcg_state);
                swap_wait      = 1 + int'(lcg_state[31:30]);
            end
            if (fb_swapped && !applied)
                swapped_samples++;
            if (applied)
            begin
                applied_count++;
                swapped_at_applied = swapped_samples;
                drop_swapped       = 1'b1;
            end
        end
    end

    always @(posedge aclk)
    begin
        cycles++;
        assert (cycles <= cycle_limit)
        else stop_on_error($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end

    initial
    begin
        int r;
        arst_n             = 1'b0;
        apply              = 1'b0;
        cmd_memset_color   = 1'b0;
        cmd_memset_depth   = 1'b0;
        cmd_memset_stencil = 1'b0;
        cmd_swap           = 1'b0;
        enable_scissor     = 1'b0;
        scissor_start_x    = '0;
        scissor_start_y    = '0;
        scissor_end_x      = '0;
        scissor_end_y      = '0;
        x_resolution       = '0;
        y_resolution       = '0;
        color_addr         = '0;
        depth_addr         = '0;
        stencil_addr       = '0;
        clear_color        = '0;
        clear_depth        = '0;
        clear_stencil      = '0;
        color_mask         = 1'b0;
        depth_mask         = 1'b0;
        stencil_mask       = 1'b0;
        fill_table();
        for (r = 0; r < NUM_ROWS; r++)
            cycle_limit += 8 * rows[r].xres * rows[r].yres;
        repeat (3) @(negedge aclk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("applied", 32'(applied), 32'd0);
        check_value("swap_fb", 32'(swap_fb), 32'd0);
        check_value("mem_wvalid", 32'(mem_wvalid), 32'd0);
        check_value("fb_addr", fb_addr, 32'd0);
        arst_n = 1'b1;
        for (r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== fb_memset_top.f ====
+incdir+hdl
hdl/raster_pkg.sv
hdl/fb_mem_if.sv
hdl/fb_cmd_sequencer.sv
hdl/fb_clear_unit.sv
hdl/fb_write_arbiter.sv
hdl/fb_memset_top.sv
verif/fb_memset_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the framebuffer memset testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f fb_memset_top.f \
    --top-module fb_memset_tb -o fb_memset_sim &&
./obj_dir/fb_memset_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF '** PASS **' sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
